// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_limb_link
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only if the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
src/limb_link_pkg.sv
src/sample_if.sv
src/param_bank.sv
src/sim_tick_gen.sv
src/waveform_store.sv
src/spi_frame_tx.sv
src/spi_frame_rx.sv
src/limb_link_top.sv
testbench/limb_link_props.sv
testbench/tb_limb_link.sv

// File: src/limb_link_pkg.sv
package limb_link_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // one waveform element or one link word
    localparam int WORD_W = 32;
    // host pipe, two beats per element
    localparam int PIPE_W = 16;
    localparam int CFG_ADDR_W = 4;
    localparam int TICK_HALF_W = 18;
    localparam int SPI_DIV_W = 8;

    //////////////////////////////
    // config bank map
    //////////////////////////////

    // same index as the old trigger for the tick rate
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_TICK_HALF = 4'd7;
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_SPI_DIV = 4'd8;

    // defaults after reset
    localparam logic [TICK_HALF_W-1:0] TICK_HALF_RESET = 18'd600;
    // sck half-period of 14 clocks
    localparam logic [SPI_DIV_W-1:0] SPI_DIV_RESET = 8'd13;

endpackage

// File: src/limb_link_top.sv
`timescale 1ns/1ps

module limb_link_top import limb_link_pkg::*; #(
    parameter int WAVE_DEPTH = 64
) (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    // config bank writes
    input  logic                  i_cfg_valid,
    input  logic [CFG_ADDR_W-1:0] i_cfg_addr,
    input  logic [PIPE_W-1:0]     i_cfg_data,
    // waveform pipe, low half first
    input  logic                  i_pipe_valid,
    input  logic [PIPE_W-1:0]     i_pipe_data,
    input  logic                  i_repop,
    // partner link in
    input  logic                  i_spi_sck,
    input  logic                  i_spi_ssel,
    input  logic                  i_spi_data0,
    input  logic                  i_spi_data1,
    // link out
    output logic                  o_spi_sck,
    output logic                  o_spi_ssel,
    output logic                  o_spi_data0,
    output logic                  o_spi_data1,
    output logic [WORD_W-1:0]     o_muscle_len,
    output logic                  o_wave_loaded,
    output logic [WORD_W-1:0]     o_rx_word0,
    output logic [WORD_W-1:0]     o_rx_word1,
    output logic                  o_rx_valid
);

    logic [TICK_HALF_W-1:0] tick_half;
    logic [SPI_DIV_W-1:0]   spi_div;
    logic                   sim_tick;

    // store to sender
    sample_if smp ();

    param_bank u_param_bank (
        .i_clk(ep50trig), .i_rst(reset_global), .i_cfg_valid(i_cfg_valid),
        .i_cfg_addr(i_cfg_addr), .i_cfg_data(i_cfg_data),
        .o_tick_half(tick_half), .o_spi_div(spi_div)
    );

    sim_tick_gen u_sim_tick_gen (
        .i_clk(ep50trig), .i_rst(reset_global), .i_tick_half(tick_half), .o_tick(sim_tick)
    );

    waveform_store #(.WAVE_DEPTH(WAVE_DEPTH)) u_waveform_store (
        .i_clk(ep50trig), .i_rst(reset_global), .i_pipe_valid(i_pipe_valid),
        .i_pipe_data(i_pipe_data), .i_repop(i_repop), .i_tick(sim_tick),
        .o_wave_loaded(o_wave_loaded), .o_muscle_len(o_muscle_len), .src(smp.source)
    );

    spi_frame_tx u_spi_frame_tx (
        .i_clk(ep50trig), .i_rst(reset_global), .i_spi_div(spi_div), .snk(smp.sink),
        .o_sck(o_spi_sck), .o_ssel(o_spi_ssel), .o_data0(o_spi_data0), .o_data1(o_spi_data1)
    );

    spi_frame_rx u_spi_frame_rx (
        .i_clk(ep50trig), .i_rst(reset_global), .i_sck(i_spi_sck), .i_ssel(i_spi_ssel),
        .i_data0(i_spi_data0), .i_data1(i_spi_data1),
        .o_word0(o_rx_word0), .o_word1(o_rx_word1), .o_valid(o_rx_valid)
    );

endmodule

// File: src/param_bank.sv
`timescale 1ns/1ps

module param_bank import limb_link_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst,
    // host write strobe, always accepted
    input  logic                   i_cfg_valid,
    input  logic [CFG_ADDR_W-1:0]  i_cfg_addr,
    input  logic [PIPE_W-1:0]      i_cfg_data,
    output logic [TICK_HALF_W-1:0] o_tick_half,
    output logic [SPI_DIV_W-1:0]   o_spi_div
);

    //////////////////////////////
    // register writes
    //////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_tick_half <= TICK_HALF_RESET;
            o_spi_div   <= SPI_DIV_RESET;
        end else if (i_cfg_valid) begin
            // decode by address, new value live after this edge
            case (i_cfg_addr)
                CFG_ADDR_TICK_HALF: begin
                    // 16-bit host word zero-extended to 18
                    o_tick_half <= TICK_HALF_W'(i_cfg_data);
                end
                CFG_ADDR_SPI_DIV: begin
                    // low byte only
                    o_spi_div <= i_cfg_data[SPI_DIV_W-1:0];
                end
                default: begin
                    // unknown address, nothing to write
                end
            endcase
        end
    end

endmodule

// File: src/sample_if.sv
`timescale 1ns/1ps

// one sample = two link words, valid/ready
interface sample_if import limb_link_pkg::*; ();

    logic              valid;
    logic              ready;
    logic [WORD_W-1:0] word0;
    logic [WORD_W-1:0] word1;

    // store side, offers elements
    modport source (output valid, output word0, output word1, input ready);

    // spi sender side
    modport sink (input valid, input word0, input word1, output ready);

endinterface

// File: src/sim_tick_gen.sv
`timescale 1ns/1ps

module sim_tick_gen import limb_link_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic [TICK_HALF_W-1:0] i_tick_half,
    output logic                   o_tick
);

    // full tick period, twice the half-period
    logic [TICK_HALF_W:0] tick_period;
    logic [TICK_HALF_W:0] tick_cnt;

    assign tick_period = {i_tick_half, 1'b0};

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            tick_cnt <= '0;
            o_tick   <= 1'b0;
        end else if (i_tick_half == '0) begin
            // zero half-period parks the generator
            tick_cnt <= '0;
            o_tick   <= 1'b0;
        end else if (tick_cnt >= tick_period - 1'b1) begin
            // >= so a shrunk period wraps at once
            tick_cnt <= '0;
            o_tick   <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            o_tick   <= 1'b0;
        end
    end

endmodule

// File: src/spi_frame_rx.sv
`timescale 1ns/1ps

module spi_frame_rx import limb_link_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_sck,
    input  logic              i_ssel,
    input  logic              i_data0,
    input  logic              i_data1,
    output logic [WORD_W-1:0] o_word0,
    output logic [WORD_W-1:0] o_word1,
    output logic              o_valid
);

    // control syncs, bit 1 ssel, bit 0 sck
    logic [1:0]        ctl_meta;
    logic [1:0]        ctl_sync;
    logic [1:0]        ctl_prev;
    // data syncs, same depth as sck
    logic [1:0]        dat_meta;
    logic [1:0]        dat_sync;
    logic [WORD_W-1:0] shift0;
    logic [WORD_W-1:0] shift1;
    // counts past 32 so long frames fail too
    logic [5:0]        bit_cnt;
    logic              frame_ok;
    logic              frame_ok_d;
    logic              sck_rise;
    logic              ssel_rise;

    assign sck_rise = ctl_sync[0] && !ctl_prev[0] && !ctl_sync[1];
    assign ssel_rise = ctl_sync[1] && !ctl_prev[1];

    //////////////////////////////
    // sync, count, pulse
    //////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            // ssel idles high
            ctl_meta   <= 2'b10;
            ctl_sync   <= 2'b10;
            ctl_prev   <= 2'b10;
            bit_cnt    <= '0;
            frame_ok   <= 1'b0;
            frame_ok_d <= 1'b0;
            o_valid    <= 1'b0;
        end else begin
            ctl_meta <= {i_ssel, i_sck};
            ctl_sync <= ctl_meta;
            ctl_prev <= ctl_sync;
            if (ctl_sync[1]) bit_cnt <= '0;
            else if (sck_rise && bit_cnt != 6'h3f) bit_cnt <= bit_cnt + 1'b1;
            // three stages from synced ssel rise to o_valid
            frame_ok   <= ssel_rise && (bit_cnt == 6'd32);
            frame_ok_d <= frame_ok;
            o_valid    <= frame_ok_d;
        end
    end

    always_ff @(posedge i_clk) begin
        dat_meta <= {i_data1, i_data0};
        dat_sync <= dat_meta;
        if (sck_rise) begin
            shift0 <= {shift0[WORD_W-2:0], dat_sync[0]};
            shift1 <= {shift1[WORD_W-2:0], dat_sync[1]};
        end
        // hold until the next good frame
        if (frame_ok) begin
            o_word0 <= shift0;
            o_word1 <= shift1;
        end
    end

endmodule

// File: src/spi_frame_tx.sv
`timescale 1ns/1ps

module spi_frame_tx import limb_link_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    // sck half-period minus one
    input  logic [SPI_DIV_W-1:0] i_spi_div,
    sample_if.sink               snk,
    output logic                 o_sck,
    output logic                 o_ssel,
    output logic                 o_data0,
    output logic                 o_data1
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SHIFT = 2'd1;
    localparam logic [1:0] ST_GAP   = 2'd2;

    logic [1:0]          state;
    logic [SPI_DIV_W-1:0] div_cnt;
    logic [4:0]          bit_cnt;
    logic [WORD_W-1:0]   shift0;
    logic [WORD_W-1:0]   shift1;
    logic                half_done;
    logic                sck_fall;

    assign snk.ready = (state == ST_IDLE);
    // >= keeps a lowered divider from overrunning
    assign half_done = (div_cnt >= i_spi_div);
    assign sck_fall = (state == ST_SHIFT) && half_done && o_sck;
    // msb first on both lanes
    assign o_data0 = shift0[WORD_W-1];
    assign o_data1 = shift1[WORD_W-1];

    //////////////////////////////
    // frame sequencer
    //////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state   <= ST_IDLE;
            o_sck   <= 1'b0;
            o_ssel  <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // accept, ssel drops on the same edge
                    if (snk.valid) begin
                        state   <= ST_SHIFT;
                        o_ssel  <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                ST_SHIFT: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        o_sck   <= ~o_sck;
                        if (o_sck) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            // 32nd falling edge ends the data phase
                            if (bit_cnt == 5'd31) state <= ST_GAP;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    // closing gap, one half-period with sck low
                    if (half_done) begin
                        state   <= ST_IDLE;
                        o_ssel  <= 1'b1;
                        div_cnt <= '0;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // words latched on transfer, next bit on each falling sck
    always_ff @(posedge i_clk) begin
        if (snk.valid && snk.ready) begin
            shift0 <= snk.word0;
            shift1 <= snk.word1;
        end else if (sck_fall) begin
            shift0 <= {shift0[WORD_W-2:0], 1'b0};
            shift1 <= {shift1[WORD_W-2:0], 1'b0};
        end
    end

endmodule

// File: src/waveform_store.sv
`timescale 1ns/1ps

module waveform_store import limb_link_pkg::*; #(
    parameter int WAVE_DEPTH = 64
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_pipe_valid,
    input  logic [PIPE_W-1:0] i_pipe_data,
    input  logic              i_repop,
    input  logic              i_tick,
    output logic              o_wave_loaded,
    output logic [WORD_W-1:0] o_muscle_len,
    sample_if.source          src
);

    localparam int ADDR_W = (WAVE_DEPTH > 1) ? $clog2(WAVE_DEPTH) : 1;
    localparam logic [ADDR_W:0] FULL_CNT = (ADDR_W+1)'(WAVE_DEPTH);

    logic [WORD_W-1:0] mem [WAVE_DEPTH];
    logic [PIPE_W-1:0] low_half;
    // next pipe beat is the high half
    logic              high_next;
    logic [ADDR_W:0]   wr_count;
    logic [ADDR_W-1:0] rd_ptr;
    logic [WORD_W-1:0] offer_word;
    logic              store_en;
    logic              offer_load;
    logic              xfer;

    // pair complete and room left
    assign store_en = i_pipe_valid && high_next && (wr_count != FULL_CNT);
    // ticks during a pending offer fall through here
    assign offer_load = i_tick && o_wave_loaded && !src.valid;
    assign xfer = src.valid && src.ready;
    assign o_wave_loaded = (wr_count != '0);
    // both lanes carry the same element
    assign src.word0 = offer_word;
    assign src.word1 = offer_word;

    //////////////////////////////
    // pointers and handshake
    //////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            high_next <= 1'b0;
            wr_count  <= '0;
            rd_ptr    <= '0;
            src.valid <= 1'b0;
        end else begin
            if (i_pipe_valid) high_next <= ~high_next;
            if (store_en) wr_count <= wr_count + 1'b1;
            // repop wins over a same-cycle advance
            if (i_repop) begin
                rd_ptr <= '0;
            end else if (xfer) begin
                // wrap at the stored count, not the depth
                if ({1'b0, rd_ptr} + 1'b1 >= wr_count) rd_ptr <= '0;
                else rd_ptr <= rd_ptr + 1'b1;
            end
            if (xfer) src.valid <= 1'b0;
            else if (offer_load) src.valid <= 1'b1;
        end
    end

    // storage and data path
    always_ff @(posedge i_clk) begin
        if (i_pipe_valid && !high_next) low_half <= i_pipe_data;
        if (store_en) mem[wr_count[ADDR_W-1:0]] <= {i_pipe_data, low_half};
        if (offer_load) offer_word <= mem[rd_ptr];
        if (xfer) o_muscle_len <= offer_word;
    end

endmodule

// File: testbench/limb_link_props.sv
`timescale 1ns/1ps

module limb_link_props (
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_sck,
    input logic        i_ssel,
    input logic        i_valid,
    input logic        i_ready,
    input logic [31:0] i_word,
    input logic        i_rx_valid
);

    // failure counts, read by the testbench at the end
    int sck_fails = 0;
    int hold_fails = 0;
    int pulse_fails = 0;

    //////////////////////////////
    // link and handshake rules
    //////////////////////////////

    // sck parked low outside a frame
    a_sck_idle: assert property (@(posedge i_clk) disable iff (i_rst) i_ssel |-> !i_sck)
        else begin
            $error("sck high while ssel is high");
            sck_fails = sck_fails + 1;
        end

    // offer held with a stable word until the sender takes it
    a_offer_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_valid && !i_ready) |=> (i_valid && $stable(i_word)))
        else begin
            $error("sample offer dropped or changed before ready");
            hold_fails = hold_fails + 1;
        end

    // received word strobe is a single cycle
    a_rx_pulse: assert property (@(posedge i_clk) disable iff (i_rst) i_rx_valid |=> !i_rx_valid)
        else begin
            $error("rx valid longer than one cycle");
            pulse_fails = pulse_fails + 1;
        end

endmodule

bind limb_link_top limb_link_props u_props (
    .i_clk(ep50trig), .i_rst(reset_global), .i_sck(o_spi_sck), .i_ssel(o_spi_ssel),
    .i_valid(smp.valid), .i_ready(smp.ready), .i_word(smp.word0), .i_rx_valid(o_rx_valid)
);

// File: testbench/tb_limb_link.sv
`timescale 1ns/1ps

module tb_limb_link import limb_link_pkg::*; ();

    localparam int WAVE_COUNT = 5;
    localparam int PARTNER_N = 64;
    localparam int IDLE_CYCLES = 3000;
    localparam int FRAMES_PLANNED = 23;
    localparam int MAX_HALF = 600;
    // every planned frame at the slowest tick, plus idle phase and margin
    localparam int CYCLE_LIMIT = FRAMES_PLANNED * 2 * MAX_HALF + IDLE_CYCLES + 2000;

    logic ep50trig = 1'b0;
    logic reset_global;
    logic i_cfg_valid;
    logic [CFG_ADDR_W-1:0] i_cfg_addr;
    logic [PIPE_W-1:0] i_cfg_data;
    logic i_pipe_valid;
    logic [PIPE_W-1:0] i_pipe_data;
    logic i_repop;
    // lane 1 from the partner model
    logic i_spi_data1 = 1'b0;
    logic o_spi_sck, o_spi_ssel, o_spi_data0, o_spi_data1;
    logic [WORD_W-1:0] o_muscle_len, o_rx_word0, o_rx_word1;
    logic o_wave_loaded, o_rx_valid;

    logic [31:0] wave_words [WAVE_COUNT];
    logic [31:0] partner_words [PARTNER_N];
    integer seed;
    int errors = 0;
    int frame_k = 0;
    int rx_total = 0;
    int cycle = 0;
    int total;
    // link monitor results
    int ssel_fall_at = 0;
    int ssel_gap = 0;
    int sck_rise_at = 0;
    int sck_high = 0;
    logic ssel_prev = 1'b1;
    logic sck_prev = 1'b0;
    // our own lane 1 output, sampled on rising sck
    logic [31:0] lane1_bits = '0;
    // partner driver state
    logic ssel_seen = 1'b1;
    logic sck_seen = 1'b0;
    logic [31:0] cur_word = '0;
    int bit_idx = 0;
    int tx_frame = 0;

    // loopback on sck, ssel and lane 0
    limb_link_top #(.WAVE_DEPTH(64)) uut (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .i_cfg_valid(i_cfg_valid), .i_cfg_addr(i_cfg_addr), .i_cfg_data(i_cfg_data),
        .i_pipe_valid(i_pipe_valid), .i_pipe_data(i_pipe_data), .i_repop(i_repop),
        .i_spi_sck(o_spi_sck), .i_spi_ssel(o_spi_ssel), .i_spi_data0(o_spi_data0),
        .i_spi_data1(i_spi_data1),
        .o_spi_sck(o_spi_sck), .o_spi_ssel(o_spi_ssel), .o_spi_data0(o_spi_data0),
        .o_spi_data1(o_spi_data1), .o_muscle_len(o_muscle_len), .o_wave_loaded(o_wave_loaded),
        .o_rx_word0(o_rx_word0), .o_rx_word1(o_rx_word1), .o_rx_valid(o_rx_valid)
    );

    always #4 ep50trig = ~ep50trig;

    //////////////////////////////
    // reference and check
    //////////////////////////////

    // frame k after load or repop carries stored word k mod count
    function automatic logic [31:0] expected_element(input int k);
        return wave_words[k % WAVE_COUNT];
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, expected);
            errors = errors + 1;
        end
    endtask

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    task automatic load_waveform();
        for (int i = 0; i < WAVE_COUNT; i++) begin
            @(posedge ep50trig);
            #1;
            i_pipe_valid = 1'b1;
            i_pipe_data = wave_words[i][15:0];
            @(posedge ep50trig);
            #1;
            i_pipe_data = wave_words[i][31:16];
        end
        @(posedge ep50trig);
        #1;
        i_pipe_valid = 1'b0;
    endtask

    task automatic write_config(input logic [CFG_ADDR_W-1:0] addr, input logic [15:0] data);
        @(posedge ep50trig);
        #1;
        i_cfg_valid = 1'b1;
        i_cfg_addr = addr;
        i_cfg_data = data;
        @(posedge ep50trig);
        #1;
        i_cfg_valid = 1'b0;
    endtask

    task automatic pulse_repop();
        @(posedge ep50trig);
        #1;
        i_repop = 1'b1;
        @(posedge ep50trig);
        #1;
        i_repop = 1'b0;
        // playback restarts at element 0
        frame_k = 0;
    endtask

    // waits for each received frame, compares both lanes and the muscle length
    task automatic collect_frames(input int count, input bit check_len);
        for (int n = 0; n < count; n++) begin
            @(negedge ep50trig);
            while (!o_rx_valid) @(negedge ep50trig);
            check_value(o_rx_word0, expected_element(frame_k), "lane 0 element");
            check_value(lane1_bits, expected_element(frame_k), "lane 1 element");
            // a waiting offer moves it on before the frame is reported
            if (check_len) begin
                check_value(o_muscle_len, expected_element(frame_k), "muscle length");
            end
            check_value(o_rx_word1, partner_words[rx_total % PARTNER_N], "lane 1 partner word");
            frame_k = frame_k + 1;
            rx_total = rx_total + 1;
        end
    endtask

    //////////////////////////////
    // partner lane 1 and monitor
    //////////////////////////////

    // new word per frame, next bit on each falling sck
    always @(posedge ep50trig) begin
        #1;
        if (ssel_seen && !o_spi_ssel) begin
            cur_word = partner_words[tx_frame % PARTNER_N];
            tx_frame = tx_frame + 1;
            bit_idx = 31;
            i_spi_data1 = cur_word[31];
        end else if (!o_spi_ssel && sck_seen && !o_spi_sck && bit_idx > 0) begin
            bit_idx = bit_idx - 1;
            i_spi_data1 = cur_word[bit_idx];
        end
        ssel_seen = o_spi_ssel;
        sck_seen = o_spi_sck;
    end

    // sck high time and ssel fall spacing, in clock cycles
    always @(negedge ep50trig) begin
        if (ssel_prev && !o_spi_ssel) begin
            ssel_gap = cycle - ssel_fall_at;
            ssel_fall_at = cycle;
        end
        if (!sck_prev && o_spi_sck) begin
            sck_rise_at = cycle;
            lane1_bits = {lane1_bits[30:0], o_spi_data1};
        end
        if (sck_prev && !o_spi_sck) sck_high = cycle - sck_rise_at;
        ssel_prev = o_spi_ssel;
        sck_prev = o_spi_sck;
    end

    // hang guard
    always @(posedge ep50trig) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles, frames still missing", cycle);
            $display("errors: %0d", errors);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        seed = 89;
        reset_global = 1'b1;
        i_cfg_valid = 1'b0;
        i_cfg_addr = '0;
        i_cfg_data = '0;
        i_pipe_valid = 1'b0;
        i_pipe_data = '0;
        i_repop = 1'b0;
        for (int i = 0; i < WAVE_COUNT; i++) wave_words[i] = $random(seed);
        for (int i = 0; i < PARTNER_N; i++) partner_words[i] = $random(seed);
        repeat (2) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;

        // idle state after reset
        @(negedge ep50trig);
        check_value(32'(o_spi_ssel), 32'd1, "ssel after reset");
        check_value(32'(o_spi_sck), 32'd0, "sck after reset");
        check_value(32'(o_wave_loaded), 32'd0, "loaded after reset");
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            @(negedge ep50trig);
            check_value(32'(o_rx_valid), 32'd0, "rx valid before load");
        end

        load_waveform();
        @(negedge ep50trig);
        check_value(32'(o_wave_loaded), 32'd1, "loaded after pipe writes");
        collect_frames(12, 1'b1);

        // restart mid-run
        pulse_repop();
        collect_frames(4, 1'b1);

        // faster sck and tick, one frame to settle into the new period
        write_config(CFG_ADDR_SPI_DIV, 16'd5);
        write_config(CFG_ADDR_TICK_HALF, 16'd400);
        collect_frames(4, 1'b1);
        check_value(32'(sck_high), 32'd6, "sck high cycles");
        check_value(32'(ssel_gap), 32'd800, "ssel fall spacing");

        // tick shorter than a frame, offers wait for the busy sender
        write_config(CFG_ADDR_TICK_HALF, 16'd100);
        collect_frames(3, 1'b0);

        total = errors + uut.u_props.sck_fails + uut.u_props.hold_fails
              + uut.u_props.pulse_fails;
        $display("errors: %0d (checks %0d, assertions %0d)", total, errors, total - errors);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
